/* compile.f */
+incdir+.
sign_pkg.sv
sign_config_regs.sv
sign_sequencer.sv
port_select.sv
sign_online_ctrl.sv
tb_sign_online.sv

/* port_select.sv */
module port_select #(
    parameter type REQ_T = sign_pkg::hash_req_t,
    parameter type RSP_T = sign_pkg::hash_rsp_t,
    parameter int  N     = 3,
    parameter int  STB_W = 3
) (
    input  logic [$clog2(N)-1:0] i_sel,
    input  REQ_T                 i_req [N],
    output REQ_T                 o_req,
    input  RSP_T                 i_rsp,
    output RSP_T                 o_rsp [N],
    input  logic [STB_W-1:0]     i_rsp_stb,
    output logic [STB_W-1:0]     o_rsp_stb [N]
);

    // out of range codes give an idle request
    always_comb begin
        if (int'(i_sel) < N) begin
            o_req = i_req[i_sel];
        end else begin
            o_req = '0;
        end
    end

    // payload goes to everyone, strobes only to the owner
    for (genvar k = 0; k < N; k++) begin : g_src
        assign o_rsp[k]     = i_rsp;
        assign o_rsp_stb[k] = (int'(i_sel) == k) ? i_rsp_stb : '0;
    end

endmodule

/* sign_config_regs.sv */
`include "sign_defines.svh"

module sign_config_regs (
    input  logic                i_clk,
    input  logic                i_rst,
    input  logic                i_cfg_wr,
    input  sign_pkg::sign_cfg_t i_cfg,
    input  logic                i_busy,
    output sign_pkg::sign_cfg_t o_cfg
);

    import sign_pkg::*;

    sign_cfg_t cfg_clamped;

    // saturate each bound to its max
    always_comb begin
        cfg_clamped.tau_count = (i_cfg.tau_count > 5'(`TAU_MAX)) ?
                                5'(`TAU_MAX) : i_cfg.tau_count;
        cfg_clamped.party_count = (i_cfg.party_count > 4'(`PARTY_MAX)) ?
                                  4'(`PARTY_MAX) : i_cfg.party_count;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_cfg.tau_count   <= 5'(`TAU_DEFAULT);
            o_cfg.party_count <= 4'(`PARTY_DEFAULT);
        end else if (i_cfg_wr && !i_busy) begin
            // writes while a run is active are lost
            o_cfg <= cfg_clamped;
        end
    end

endmodule

/* sign_defines.svh */
`ifndef SIGN_DEFINES_SVH
`define SIGN_DEFINES_SVH

// ====================
// datapath widths
// ====================

// GF(2^32) word
`define WORD_W          32
// adder lanes in one arithmetic request
`define T_LANES         3
`define HASH_ADDR_W     10

// ====================
// loop bounds
// ====================

`define TAU_DEFAULT     17
`define PARTY_DEFAULT   8
`define TAU_MAX         31
`define PARTY_MAX       15

// ====================
// shared port sources
// ====================

`define HASH_SRC_N      3
`define ARITH_SRC_N     2

`endif

/* sign_online_ctrl.sv */
`include "sign_defines.svh"

module sign_online_ctrl (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    output logic                    o_done,
    input  logic                    i_cfg_wr,
    input  sign_pkg::sign_cfg_t     i_cfg,
    output sign_pkg::phase_strobe_t o_phase_start,
    input  sign_pkg::phase_strobe_t i_phase_done,
    output logic [4:0]              o_e_index,
    output logic [3:0]              o_party_index,
    input  sign_pkg::hash_req_t     i_hash_req [`HASH_SRC_N],
    output sign_pkg::hash_req_t     o_hash_req,
    input  sign_pkg::hash_rsp_t     i_hash_rsp,
    output sign_pkg::hash_rsp_t     o_hash_rsp [`HASH_SRC_N],
    input  sign_pkg::arith_req_t    i_arith_req [`ARITH_SRC_N],
    output sign_pkg::arith_req_t    o_arith_req,
    input  sign_pkg::arith_rsp_t    i_arith_rsp,
    output sign_pkg::arith_rsp_t    o_arith_rsp [`ARITH_SRC_N]
);

    import sign_pkg::*;

    sign_cfg_t  cfg;
    logic       busy;
    hash_src_e  hash_sel;
    logic       arith_sel;

    hash_rsp_t  hash_rsp_bc  [`HASH_SRC_N];
    logic [2:0] hash_stb     [`HASH_SRC_N];
    arith_rsp_t arith_rsp_bc [`ARITH_SRC_N];
    logic [1:0] arith_stb    [`ARITH_SRC_N];

    // ====================
    // control
    // ====================

    sign_config_regs u_cfg (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_cfg_wr (i_cfg_wr),
        .i_cfg    (i_cfg),
        .i_busy   (busy),
        .o_cfg    (cfg)
    );

    sign_sequencer u_seq (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .o_done        (o_done),
        .i_cfg         (cfg),
        .o_busy        (busy),
        .o_phase_start (o_phase_start),
        .i_phase_done  (i_phase_done),
        .o_e_index     (o_e_index),
        .o_party_index (o_party_index),
        .o_hash_sel    (hash_sel),
        .o_arith_sel   (arith_sel)
    );

    // ====================
    // hash port
    // ====================

    port_select #(
        .REQ_T (hash_req_t),
        .RSP_T (hash_rsp_t),
        .N     (`HASH_SRC_N),
        .STB_W (3)
    ) u_hash_sel (
        .i_sel     (hash_sel),
        .i_req     (i_hash_req),
        .o_req     (o_hash_req),
        .i_rsp     (i_hash_rsp),
        .o_rsp     (hash_rsp_bc),
        .i_rsp_stb ({i_hash_rsp.rd_en, i_hash_rsp.data_out_valid,
                     i_hash_rsp.force_done_ack}),
        .o_rsp_stb (hash_stb)
    );

    for (genvar k = 0; k < `HASH_SRC_N; k++) begin : g_hash_rsp
        assign o_hash_rsp[k] = '{addr:           hash_rsp_bc[k].addr,
                                 rd_en:          hash_stb[k][2],
                                 data_out:       hash_rsp_bc[k].data_out,
                                 data_out_valid: hash_stb[k][1],
                                 force_done_ack: hash_stb[k][0]};
    end

    // ====================
    // arithmetic port
    // ====================

    port_select #(
        .REQ_T (arith_req_t),
        .RSP_T (arith_rsp_t),
        .N     (`ARITH_SRC_N),
        .STB_W (2)
    ) u_arith_sel (
        .i_sel     (arith_sel),
        .i_req     (i_arith_req),
        .o_req     (o_arith_req),
        .i_rsp     (i_arith_rsp),
        .o_rsp     (arith_rsp_bc),
        .i_rsp_stb ({i_arith_rsp.done_mul32, i_arith_rsp.done_add32}),
        .o_rsp_stb (arith_stb)
    );

    for (genvar k = 0; k < `ARITH_SRC_N; k++) begin : g_arith_rsp
        assign o_arith_rsp[k] = '{o_mul32:    arith_rsp_bc[k].o_mul32,
                                  done_mul32: arith_stb[k][1],
                                  add_out:    arith_rsp_bc[k].add_out,
                                  done_add32: arith_stb[k][0]};
    end

endmodule

/* sign_pkg.sv */
`include "sign_defines.svh"

package sign_pkg;

    // one bit per phase engine for start and done alike
    typedef struct packed {
        logic mpc_chal;
        logic cpb;
        logic pc;
        logic evc;
        logic gssp;
    } phase_strobe_t;

    // lengths are in bits
    typedef struct packed {
        logic [`WORD_W-1:0]      data_in;
        logic                    data_out_ready;
        logic [31:0]             input_length;
        logic [31:0]             output_length;
        logic                    start;
        logic                    force_done;
    } hash_req_t;

    typedef struct packed {
        logic [`HASH_ADDR_W-1:0] addr;
        logic                    rd_en;
        logic [`WORD_W-1:0]      data_out;
        logic                    data_out_valid;
        logic                    force_done_ack;
    } hash_rsp_t;

    typedef logic [`T_LANES-1:0][`WORD_W-1:0] lane_vec_t;

    typedef struct packed {
        logic               start_mul32;
        logic [`WORD_W-1:0] x_mul32;
        logic [`WORD_W-1:0] y_mul32;
        logic               start_add32;
        lane_vec_t          in_1_add32;
        lane_vec_t          in_2_add32;
    } arith_req_t;

    typedef struct packed {
        logic [`WORD_W-1:0] o_mul32;
        logic               done_mul32;
        lane_vec_t          add_out;
        logic               done_add32;
    } arith_rsp_t;

    typedef struct packed {
        logic [4:0] tau_count;
        logic [3:0] party_count;
    } sign_cfg_t;

    typedef enum logic [1:0] {
        HSRC_MPC  = 2'd0,
        HSRC_EVC  = 2'd1,
        HSRC_GSSP = 2'd2
    } hash_src_e;

    localparam logic ARITH_SRC_CPB = 1'b0;
    localparam logic ARITH_SRC_PC  = 1'b1;

endpackage

/* sign_sequencer.sv */
module sign_sequencer (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic                    i_start,
    output logic                    o_done,
    input  sign_pkg::sign_cfg_t     i_cfg,
    output logic                    o_busy,
    output sign_pkg::phase_strobe_t o_phase_start,
    input  sign_pkg::phase_strobe_t i_phase_done,
    output logic [4:0]              o_e_index,
    output logic [3:0]              o_party_index,
    output sign_pkg::hash_src_e     o_hash_sel,
    output logic                    o_arith_sel
);

    import sign_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_MPC_START,
        S_MPC_WAIT,
        S_ROUND_LOOP,
        S_CPB_START,
        S_CPB_WAIT,
        S_PARTY_LOOP,
        S_PC_START,
        S_PC_WAIT,
        S_EVC_START,
        S_EVC_WAIT,
        S_GSSP_LOOP,
        S_GSSP_START,
        S_GSSP_WAIT,
        S_DONE
    } state_e;

    state_e     state;
    logic [4:0] e_cnt;
    logic [3:0] p_cnt;

    // ====================
    // state and counters
    // ====================

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= S_IDLE;
            e_cnt <= '0;
            p_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    e_cnt <= '0;
                    p_cnt <= '0;
                    if (i_start) begin
                        state <= S_MPC_START;
                    end
                end
                S_MPC_START: state <= S_MPC_WAIT;
                S_MPC_WAIT: begin
                    if (i_phase_done.mpc_chal) begin
                        state <= S_ROUND_LOOP;
                    end
                end
                S_ROUND_LOOP: begin
                    if (e_cnt == i_cfg.tau_count) begin
                        e_cnt <= '0;
                        state <= S_EVC_START;
                    end else begin
                        state <= S_CPB_START;
                    end
                end
                S_CPB_START: state <= S_CPB_WAIT;
                S_CPB_WAIT: begin
                    // party start follows broadcast done directly
                    if (i_phase_done.cpb) begin
                        if (i_cfg.party_count == 4'd0) begin
                            e_cnt <= e_cnt + 5'd1;
                            state <= S_ROUND_LOOP;
                        end else begin
                            state <= S_PC_START;
                        end
                    end
                end
                S_PARTY_LOOP: state <= S_PC_START;
                S_PC_START:   state <= S_PC_WAIT;
                S_PC_WAIT: begin
                    // last party closes the round here, not in the party loop
                    if (i_phase_done.pc) begin
                        if (p_cnt + 4'd1 == i_cfg.party_count) begin
                            p_cnt <= '0;
                            e_cnt <= e_cnt + 5'd1;
                            state <= S_ROUND_LOOP;
                        end else begin
                            p_cnt <= p_cnt + 4'd1;
                            state <= S_PARTY_LOOP;
                        end
                    end
                end
                S_EVC_START: state <= S_EVC_WAIT;
                S_EVC_WAIT: begin
                    if (i_phase_done.evc) begin
                        state <= S_GSSP_LOOP;
                    end
                end
                S_GSSP_LOOP: begin
                    if (e_cnt == i_cfg.tau_count) begin
                        e_cnt <= '0;
                        state <= S_DONE;
                    end else begin
                        state <= S_GSSP_START;
                    end
                end
                S_GSSP_START: state <= S_GSSP_WAIT;
                S_GSSP_WAIT: begin
                    if (i_phase_done.gssp) begin
                        e_cnt <= e_cnt + 5'd1;
                        state <= S_GSSP_LOOP;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ====================
    // outputs
    // ====================

    always_comb begin
        o_phase_start.mpc_chal = (state == S_MPC_START);
        o_phase_start.cpb      = (state == S_CPB_START);
        o_phase_start.pc       = (state == S_PC_START);
        o_phase_start.evc      = (state == S_EVC_START);
        o_phase_start.gssp     = (state == S_GSSP_START);
    end

    // hash owner follows the phase
    always_comb begin
        case (state)
            S_IDLE, S_MPC_START, S_MPC_WAIT:
                o_hash_sel = HSRC_MPC;
            S_GSSP_LOOP, S_GSSP_START, S_GSSP_WAIT, S_DONE:
                o_hash_sel = HSRC_GSSP;
            default:
                o_hash_sel = HSRC_EVC;
        endcase
    end

    assign o_arith_sel = (state == S_PC_START || state == S_PC_WAIT) ?
                         ARITH_SRC_PC : ARITH_SRC_CPB;

    assign o_done        = (state == S_DONE);
    assign o_busy        = (state != S_IDLE);
    assign o_e_index     = e_cnt;
    assign o_party_index = p_cnt;

endmodule

/* tb_sign_online.sv */
`include "sign_defines.svh"

module tb_sign_online;

    timeunit 1ns;
    timeprecision 1ps;

    import sign_pkg::*;

    // field order is mpc_chal, cpb, pc, evc, gssp from msb down
    localparam phase_strobe_t MPC_STB  = phase_strobe_t'(5'b10000);
    localparam phase_strobe_t CPB_STB  = phase_strobe_t'(5'b01000);
    localparam phase_strobe_t PC_STB   = phase_strobe_t'(5'b00100);
    localparam phase_strobe_t EVC_STB  = phase_strobe_t'(5'b00010);
    localparam phase_strobe_t GSSP_STB = phase_strobe_t'(5'b00001);

    localparam int TIMEOUT_CYCLES = 4 * (2 + 31 * (3 + 15 * 8) + 31 * 8 + 20) * 8;

    logic          i_clk = 1'b0;
    logic          i_rst;
    logic          i_start;
    logic          o_done;
    logic          i_cfg_wr;
    sign_cfg_t     i_cfg;
    phase_strobe_t o_phase_start;
    phase_strobe_t i_phase_done;
    logic [4:0]    o_e_index;
    logic [3:0]    o_party_index;
    hash_req_t     i_hash_req [`HASH_SRC_N];
    hash_req_t     o_hash_req;
    hash_rsp_t     i_hash_rsp;
    hash_rsp_t     o_hash_rsp [`HASH_SRC_N];
    arith_req_t    i_arith_req [`ARITH_SRC_N];
    arith_req_t    o_arith_req;
    arith_rsp_t    i_arith_rsp;
    arith_rsp_t    o_arith_rsp [`ARITH_SRC_N];

    // reference model state
    hash_src_e     ref_hash;
    logic          ref_in_pc;
    phase_strobe_t ref_wait;
    int            start_cnt [5];
    int            done_cnt;
    int            cycle_cnt = 0;

    sign_online_ctrl u_dut (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_start       (i_start),
        .o_done        (o_done),
        .i_cfg_wr      (i_cfg_wr),
        .i_cfg         (i_cfg),
        .o_phase_start (o_phase_start),
        .i_phase_done  (i_phase_done),
        .o_e_index     (o_e_index),
        .o_party_index (o_party_index),
        .i_hash_req    (i_hash_req),
        .o_hash_req    (o_hash_req),
        .i_hash_rsp    (i_hash_rsp),
        .o_hash_rsp    (o_hash_rsp),
        .i_arith_req   (i_arith_req),
        .o_arith_req   (o_arith_req),
        .i_arith_rsp   (i_arith_rsp),
        .o_arith_rsp   (o_arith_rsp)
    );

    always #10 i_clk = ~i_clk;

    // ====================
    // compare tasks
    // ====================

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_strobe(input string name, input phase_strobe_t exp,
                                input phase_strobe_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_index(input string name, input logic [4:0] exp,
                               input logic [4:0] act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_hash_req(input string name, input hash_req_t exp,
                                  input hash_req_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_hash_rsp(input string name, input hash_rsp_t exp,
                                  input hash_rsp_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_arith_req(input string name, input arith_req_t exp,
                                   input arith_req_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_arith_rsp(input string name, input arith_rsp_t exp,
                                   input arith_rsp_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    // ====================
    // helpers
    // ====================

    function automatic logic [319:0] rand_wide();
        logic [319:0] v;
        for (int i = 0; i < 10; i++) begin
            v[i*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    // stray done pulses on phases nobody waits for
    function automatic phase_strobe_t done_noise(input phase_strobe_t keep_low);
        logic [4:0] r;
        r = 5'($urandom) & 5'($urandom);
        return r & ~keep_low;
    endfunction

    function automatic int clamp_bound(input int v, input int max_v);
        return (v > max_v) ? max_v : v;
    endfunction

    function automatic hash_rsp_t gated_hash_rsp(input hash_rsp_t rsp, input bit owner);
        hash_rsp_t g;
        g = rsp;
        if (!owner) begin
            g.rd_en          = 1'b0;
            g.data_out_valid = 1'b0;
            g.force_done_ack = 1'b0;
        end
        return g;
    endfunction

    function automatic arith_rsp_t gated_arith_rsp(input arith_rsp_t rsp, input bit owner);
        arith_rsp_t g;
        g = rsp;
        if (!owner) begin
            g.done_mul32 = 1'b0;
            g.done_add32 = 1'b0;
        end
        return g;
    endfunction

    // one clock of stimulus, then the start and done outputs are sampled
    task automatic step_cycle(input string name, input phase_strobe_t skip,
                              input phase_strobe_t exp_start, input logic exp_done);
        @(posedge i_clk);
        i_start      <= 1'b0;
        i_cfg_wr     <= 1'b0;
        i_phase_done <= done_noise(skip);
        @(negedge i_clk);
        check_strobe(name, exp_start, o_phase_start);
        check_bit({name, " done"}, exp_done, o_done);
    endtask

    task automatic wait_start(input string name, input phase_strobe_t ph, input int gap,
                              input int e, input int p);
        for (int i = 1; i < gap; i++) begin
            step_cycle(name, ph, '0, 1'b0);
        end
        step_cycle(name, ph, ph, 1'b0);
        if (e >= 0) begin
            check_index({name, " round"}, 5'(e), o_e_index);
        end
        if (p >= 0) begin
            check_index({name, " party"}, 5'(p), {1'b0, o_party_index});
        end
    endtask

    // engine model answers with done after 1 to 6 cycles
    task automatic finish_phase(input string name, input phase_strobe_t ph, input int e,
                                input int p, input bit poke);
        int d;
        d = 1 + ($urandom % 6);
        for (int i = 1; i <= d; i++) begin
            @(posedge i_clk);
            i_cfg_wr <= poke && (i == 1);
            if (poke && i == 1) begin
                i_cfg <= sign_cfg_t'(9'($urandom));
            end
            i_phase_done <= (i == d) ? (done_noise(ph) | ph) : done_noise(ph);
            @(negedge i_clk);
            check_strobe({name, " busy"}, '0, o_phase_start);
            check_bit({name, " busy done"}, 1'b0, o_done);
            if (e >= 0) begin
                check_index({name, " held round"}, 5'(e), o_e_index);
            end
            if (p >= 0) begin
                check_index({name, " held party"}, 5'(p), {1'b0, o_party_index});
            end
        end
    endtask

    task automatic write_cfg(input sign_cfg_t c);
        @(posedge i_clk);
        i_cfg_wr     <= 1'b1;
        i_cfg        <= c;
        i_phase_done <= '0;
        @(posedge i_clk);
        i_cfg_wr <= 1'b0;
        @(negedge i_clk);
    endtask

    task automatic run_once(input string tag, input int tau, input int parties,
                            input bit poke);
        int base [5];
        int base_done;
        int exp_cnt [5];
        base      = start_cnt;
        base_done = done_cnt;
        @(posedge i_clk);
        i_start      <= 1'b1;
        i_phase_done <= '0;
        @(negedge i_clk);
        check_strobe({tag, " idle"}, '0, o_phase_start);
        wait_start({tag, " mpc"}, MPC_STB, 1, -1, -1);
        finish_phase({tag, " mpc"}, MPC_STB, -1, -1, poke);
        for (int r = 0; r < tau; r++) begin
            wait_start($sformatf("%s cpb r%0d", tag, r), CPB_STB, 2, r, -1);
            finish_phase($sformatf("%s cpb r%0d", tag, r), CPB_STB, r, -1, 1'b0);
            for (int p = 0; p < parties; p++) begin
                wait_start($sformatf("%s pc r%0d p%0d", tag, r, p), PC_STB,
                           (p == 0) ? 1 : 2, r, p);
                finish_phase($sformatf("%s pc r%0d p%0d", tag, r, p), PC_STB, r, p, 1'b0);
            end
        end
        wait_start({tag, " evc"}, EVC_STB, 2, -1, -1);
        finish_phase({tag, " evc"}, EVC_STB, -1, -1, 1'b0);
        for (int r = 0; r < tau; r++) begin
            wait_start($sformatf("%s gssp r%0d", tag, r), GSSP_STB, 2, r, -1);
            finish_phase($sformatf("%s gssp r%0d", tag, r), GSSP_STB, r, -1, 1'b0);
        end
        step_cycle({tag, " end"}, '0, '0, 1'b0);
        step_cycle({tag, " end"}, '0, '0, 1'b1);
        step_cycle({tag, " back to idle"}, '0, '0, 1'b0);
        exp_cnt[4] = 1;
        exp_cnt[3] = tau;
        exp_cnt[2] = tau * parties;
        exp_cnt[1] = 1;
        exp_cnt[0] = tau;
        for (int b = 0; b < 5; b++) begin
            check_count($sformatf("%s start count bit %0d", tag, b), exp_cnt[b],
                        start_cnt[b] - base[b]);
        end
        check_count({tag, " done count"}, 1, done_cnt - base_done);
    endtask

    // ====================
    // reference model
    // ====================

    always @(posedge i_clk) begin
        if (i_rst) begin
            ref_hash  <= HSRC_MPC;
            ref_in_pc <= 1'b0;
            ref_wait  <= '0;
            done_cnt  <= 0;
            for (int b = 0; b < 5; b++) begin
                start_cnt[b] <= 0;
            end
        end else begin
            for (int b = 0; b < 5; b++) begin
                if (o_phase_start[b]) begin
                    start_cnt[b] <= start_cnt[b] + 1;
                end
            end
            if (o_phase_start != 5'b0) begin
                ref_wait <= o_phase_start;
            end
            if (o_phase_start.pc) begin
                ref_in_pc <= 1'b1;
            end
            if ((i_phase_done & ref_wait) != 5'b0) begin
                ref_wait <= '0;
                if (ref_wait.mpc_chal) begin
                    ref_hash <= HSRC_EVC;
                end
                if (ref_wait.evc) begin
                    ref_hash <= HSRC_GSSP;
                end
                if (ref_wait.pc) begin
                    ref_in_pc <= 1'b0;
                end
            end
            if (o_done) begin
                done_cnt <= done_cnt + 1;
                ref_hash <= HSRC_MPC;
            end
        end
    end

    // routing checks on both ports every cycle
    always @(negedge i_clk) begin : route_check
        int arith_owner;
        if (!i_rst) begin
            check_hash_req("hash request mux", i_hash_req[ref_hash], o_hash_req);
            for (int k = 0; k < `HASH_SRC_N; k++) begin
                check_hash_rsp($sformatf("hash response to source %0d", k),
                               gated_hash_rsp(i_hash_rsp, k == int'(ref_hash)),
                               o_hash_rsp[k]);
            end
            arith_owner = (ref_in_pc || o_phase_start.pc) ? 1 : 0;
            check_arith_req("arith request mux", i_arith_req[arith_owner], o_arith_req);
            for (int k = 0; k < `ARITH_SRC_N; k++) begin
                check_arith_rsp($sformatf("arith response to source %0d", k),
                                gated_arith_rsp(i_arith_rsp, k == arith_owner),
                                o_arith_rsp[k]);
            end
        end
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the sequencer never finished", cycle_cnt);
            stop_on_failure();
        end
    end

    // ====================
    // stimulus
    // ====================

    // random traffic on every hash and arithmetic source
    initial begin : bus_traffic
        logic [319:0] bits;
        for (int k = 0; k < `HASH_SRC_N; k++) begin
            i_hash_req[k] = '0;
        end
        for (int k = 0; k < `ARITH_SRC_N; k++) begin
            i_arith_req[k] = '0;
        end
        i_hash_rsp  = '0;
        i_arith_rsp = '0;
        forever begin
            @(posedge i_clk);
            for (int k = 0; k < `HASH_SRC_N; k++) begin
                bits = rand_wide();
                i_hash_req[k] <= bits[$bits(hash_req_t)-1:0];
            end
            for (int k = 0; k < `ARITH_SRC_N; k++) begin
                bits = rand_wide();
                i_arith_req[k] <= bits[$bits(arith_req_t)-1:0];
            end
            bits = rand_wide();
            i_hash_rsp <= bits[$bits(hash_rsp_t)-1:0];
            bits = rand_wide();
            i_arith_rsp <= bits[$bits(arith_rsp_t)-1:0];
        end
    end

    initial begin : main_seq
        sign_cfg_t c;
        void'($urandom(92063));
        i_rst        = 1'b1;
        i_start      = 1'b0;
        i_cfg_wr     = 1'b0;
        i_cfg        = '0;
        i_phase_done = '0;
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;
        @(negedge i_clk);
        check_strobe("after reset", '0, o_phase_start);
        check_bit("after reset done", 1'b0, o_done);

        // reset bounds and a dropped write during the run
        run_once("defaults", `TAU_DEFAULT, `PARTY_DEFAULT, 1'b1);

        c = sign_cfg_t'(9'($urandom));
        write_cfg(c);
        run_once("random", clamp_bound(c.tau_count, `TAU_MAX),
                 clamp_bound(c.party_count, `PARTY_MAX), 1'b1);

        c.tau_count   = 5'd0;
        c.party_count = 4'($urandom);
        write_cfg(c);
        run_once("no rounds", 0, clamp_bound(c.party_count, `PARTY_MAX), 1'b0);

        c.tau_count   = 5'($urandom);
        c.party_count = 4'd0;
        write_cfg(c);
        run_once("no parties", clamp_bound(c.tau_count, `TAU_MAX), 0, 1'b1);

        $display("Test passed");
        $finish;
    end

endmodule
